//--- rtl/corebus_pkg.sv
/* corebus types and constants */
`default_nettype none

package corebus_pkg;

  // bus field widths.
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int LEN_WIDTH  = 2;
  localparam int ID_WIDTH   = 4;

  // depth of the memory target.
  localparam int MEM_WORDS = 64;

  typedef logic [ADDR_WIDTH-1:0] corebus_addr_t;
  typedef logic [DATA_WIDTH-1:0] corebus_data_t;
  typedef logic [LEN_WIDTH-1:0]  corebus_len_t;
  typedef logic [ID_WIDTH-1:0]   corebus_id_t;

  // also used as the response kind.
  typedef enum logic [1:0] {
    CMD_READ  = 2'b00,
    CMD_WRITE = 2'b01
  } corebus_opcode_e;

  // len is burst length minus one.
  typedef struct packed {
    corebus_opcode_e opcode;
    corebus_id_t     id;
    corebus_addr_t   addr;
    corebus_len_t    len;
  } corebus_command_t;

  typedef struct packed {
    corebus_data_t data;
    logic          last;
  } corebus_write_data_t;

  typedef struct packed {
    corebus_opcode_e kind;
    corebus_id_t     id;
    corebus_data_t   data;
    logic            error;
    logic            last;
  } corebus_response_t;

  // target FSM states.
  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    READ_BURST  = 2'b01,
    WRITE_BURST = 2'b10,
    WRITE_RESP  = 2'b11
  } corebus_resp_state_e;

endpackage

`default_nettype wire

//--- rtl/corebus_slice_stage.sv
/* full-bandwidth register slice */
`timescale 1ns/10ps
`default_nettype none

module corebus_slice_stage #(
  parameter int WIDTH = 8
)(
  input  var              i_clk,
  input  var              i_rst_n,
  input  var              i_valid,
  output var              o_ready,
  input  var [WIDTH-1:0]  i_data,
  output var              o_valid,
  input  var              i_ready,
  output var [WIDTH-1:0]  o_data
);
  logic             main_valid;
  logic [WIDTH-1:0] main_data;
  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             push;
  logic             pop;
  logic             main_load;

  // ready depends on the skid entry only.
  always_comb begin
    o_ready   = !skid_valid;
    o_valid   = main_valid;
    o_data    = main_data;
    push      = i_valid && o_ready;
    pop       = main_valid && i_ready;
    main_load = pop || !main_valid;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid || push;
      end
      if (skid_valid && main_load) begin
        skid_valid <= 1'b0;
      end else if (push && !main_load) begin
        skid_valid <= 1'b1;
      end
    end
  end

  // skid entry drains first to keep order.
  always_ff @(posedge i_clk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (push) begin
        main_data <= i_data;
      end
    end
    if (push && !main_load) begin
      skid_data <= i_data;
    end
  end

  // a stalled item must not change.
  a_output_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
  ) else $error("slice stage output changed while stalled");

endmodule

`default_nettype wire

//--- rtl/corebus_slice_chain.sv
/* slice stage chain */
`timescale 1ns/10ps
`default_nettype none

module corebus_slice_chain #(
  parameter int WIDTH  = 8,
  parameter int STAGES = 1
)(
  input  var              i_clk,
  input  var              i_rst_n,
  input  var              i_valid,
  output var              o_ready,
  input  var [WIDTH-1:0]  i_data,
  output var              o_valid,
  input  var              i_ready,
  output var [WIDTH-1:0]  o_data
);
  if (STAGES == 0) begin : g_bypass
    assign o_valid = i_valid;
    assign o_ready = i_ready;
    assign o_data  = i_data;
  end else begin : g_stages
    // index 0 is the input side.
    logic [STAGES:0]  valid;
    logic [STAGES:0]  ready;
    logic [WIDTH-1:0] data [STAGES+1];

    assign valid[0]      = i_valid;
    assign o_ready       = ready[0];
    assign data[0]       = i_data;
    assign o_valid       = valid[STAGES];
    assign ready[STAGES] = i_ready;
    assign o_data        = data[STAGES];

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
      corebus_slice_stage #(
        .WIDTH  (WIDTH  )
      ) u_stage (
        .i_clk    (i_clk      ),
        .i_rst_n  (i_rst_n    ),
        .i_valid  (valid[i]   ),
        .o_ready  (ready[i]   ),
        .i_data   (data[i]    ),
        .o_valid  (valid[i+1] ),
        .i_ready  (ready[i+1] ),
        .o_data   (data[i+1]  )
      );
    end
  end

endmodule

`default_nettype wire

//--- rtl/corebus_slicer.sv
/* corebus channel slicer */
`timescale 1ns/10ps
`default_nettype none

module corebus_slicer #(
  parameter int STAGES = 1
)(
  input  var                                  i_clk,
  input  var                                  i_rst_n,
  input  var                                  i_cmd_valid,
  output var                                  o_cmd_accept,
  input  var corebus_pkg::corebus_command_t     i_cmd,
  input  var                                  i_wdata_valid,
  output var                                  o_wdata_accept,
  input  var corebus_pkg::corebus_write_data_t  i_wdata,
  output var                                  o_resp_valid,
  input  var                                  i_resp_accept,
  output var corebus_pkg::corebus_response_t    o_resp,
  output var                                  o_cmd_valid,
  input  var                                  i_cmd_accept,
  output var corebus_pkg::corebus_command_t     o_cmd,
  output var                                  o_wdata_valid,
  input  var                                  i_wdata_accept,
  output var corebus_pkg::corebus_write_data_t  o_wdata,
  input  var                                  i_resp_valid,
  output var                                  o_resp_accept,
  input  var corebus_pkg::corebus_response_t    i_resp
);
  import corebus_pkg::*;

  localparam int COMMAND_WIDTH    = $bits(corebus_command_t);
  localparam int WRITE_DATA_WIDTH = $bits(corebus_write_data_t);
  localparam int RESPONSE_WIDTH   = $bits(corebus_response_t);

  corebus_slice_chain #(
    .WIDTH  (COMMAND_WIDTH  ),
    .STAGES (STAGES         )
  ) u_command_slicer (
    .i_clk    (i_clk        ),
    .i_rst_n  (i_rst_n      ),
    .i_valid  (i_cmd_valid  ),
    .o_ready  (o_cmd_accept ),
    .i_data   (i_cmd        ),
    .o_valid  (o_cmd_valid  ),
    .i_ready  (i_cmd_accept ),
    .o_data   (o_cmd        )
  );

  corebus_slice_chain #(
    .WIDTH  (WRITE_DATA_WIDTH ),
    .STAGES (STAGES           )
  ) u_write_data_slicer (
    .i_clk    (i_clk          ),
    .i_rst_n  (i_rst_n        ),
    .i_valid  (i_wdata_valid  ),
    .o_ready  (o_wdata_accept ),
    .i_data   (i_wdata        ),
    .o_valid  (o_wdata_valid  ),
    .i_ready  (i_wdata_accept ),
    .o_data   (o_wdata        )
  );

  // response runs master to slave.
  corebus_slice_chain #(
    .WIDTH  (RESPONSE_WIDTH ),
    .STAGES (STAGES         )
  ) u_response_slicer (
    .i_clk    (i_clk          ),
    .i_rst_n  (i_rst_n        ),
    .i_valid  (i_resp_valid   ),
    .o_ready  (o_resp_accept  ),
    .i_data   (i_resp         ),
    .o_valid  (o_resp_valid   ),
    .i_ready  (i_resp_accept  ),
    .o_data   (o_resp         )
  );

  // senders on the slave side hold valid until accepted.
  a_cmd_valid_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_cmd_valid && !o_cmd_accept) |=> i_cmd_valid
  ) else $error("command valid dropped before accept");

  a_wdata_valid_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_wdata_valid && !o_wdata_accept) |=> i_wdata_valid
  ) else $error("write data valid dropped before accept");

endmodule

`default_nettype wire

//--- rtl/corebus_mem_target.sv
/* corebus memory target */
`timescale 1ns/10ps
`default_nettype none

module corebus_mem_target (
  input  var                                  i_clk,
  input  var                                  i_rst_n,
  input  var                                  i_cmd_valid,
  output var                                  o_cmd_accept,
  input  var corebus_pkg::corebus_command_t     i_cmd,
  input  var                                  i_wdata_valid,
  output var                                  o_wdata_accept,
  input  var corebus_pkg::corebus_write_data_t  i_wdata,
  output var                                  o_resp_valid,
  input  var                                  i_resp_accept,
  output var corebus_pkg::corebus_response_t    o_resp
);
  import corebus_pkg::*;

  localparam int INDEX_WIDTH = $clog2(MEM_WORDS);

  corebus_data_t       mem [MEM_WORDS];
  corebus_resp_state_e state;
  corebus_len_t        beat_cnt;
  corebus_len_t        len_q;
  corebus_addr_t       cur_addr;
  corebus_id_t         id_q;
  logic                err_q;
  logic [ADDR_WIDTH:0] cmd_end;
  logic                cmd_fire;
  logic                wdata_fire;
  logic                resp_fire;
  logic                last_beat;

  always_comb begin
    o_cmd_accept   = state == IDLE;
    o_wdata_accept = state == WRITE_BURST;
    o_resp_valid   = (state == READ_BURST) || (state == WRITE_RESP);
    cmd_fire       = i_cmd_valid && o_cmd_accept;
    wdata_fire     = i_wdata_valid && o_wdata_accept;
    resp_fire      = o_resp_valid && i_resp_accept;
    last_beat      = beat_cnt == len_q;
    // one bit wider so the range check does not wrap.
    cmd_end = {1'b0, i_cmd.addr} + {{(ADDR_WIDTH+1-LEN_WIDTH){1'b0}}, i_cmd.len};
  end

  always_comb begin
    o_resp.kind  = (state == WRITE_RESP) ? CMD_WRITE : CMD_READ;
    o_resp.id    = id_q;
    o_resp.data  = (state == READ_BURST && !err_q) ? mem[cur_addr[INDEX_WIDTH-1:0]] : '0;
    o_resp.error = err_q;
    o_resp.last  = (state == WRITE_RESP) || last_beat;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_fire) begin
            beat_cnt <= '0;
            state    <= (i_cmd.opcode == CMD_READ) ? READ_BURST : WRITE_BURST;
          end
        end
        READ_BURST: begin
          if (resp_fire) begin
            if (last_beat) begin
              state <= IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        WRITE_BURST: begin
          if (wdata_fire) begin
            if (last_beat) begin
              state <= WRITE_RESP;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (resp_fire) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      cur_addr <= i_cmd.addr;
      id_q     <= i_cmd.id;
      len_q    <= i_cmd.len;
      err_q    <= cmd_end >= MEM_WORDS;
    end else if ((state == READ_BURST && resp_fire) || wdata_fire) begin
      cur_addr <= cur_addr + 1'b1;
    end
  end

  // error bursts are consumed but not stored.
  always_ff @(posedge i_clk) begin
    if (wdata_fire && !err_q) begin
      mem[cur_addr[INDEX_WIDTH-1:0]] <= i_wdata.data;
    end
  end

  a_wdata_last: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    wdata_fire |-> (i_wdata.last == last_beat)
  ) else $error("write data last does not match burst length");

endmodule

`default_nettype wire

//--- rtl/corebus_top.sv
/* sliced corebus with memory target */
`timescale 1ns/10ps
`default_nettype none

module corebus_top #(
  parameter int STAGES = 2
)(
  input  var                                  i_clk,
  input  var                                  i_rst_n,
  input  var                                  i_cmd_valid,
  output var                                  o_cmd_accept,
  input  var corebus_pkg::corebus_command_t     i_cmd,
  input  var                                  i_wdata_valid,
  output var                                  o_wdata_accept,
  input  var corebus_pkg::corebus_write_data_t  i_wdata,
  output var                                  o_resp_valid,
  input  var                                  i_resp_accept,
  output var corebus_pkg::corebus_response_t    o_resp
);
  import corebus_pkg::*;

  // target side of the slicer.
  logic                cmd_valid;
  logic                cmd_accept;
  corebus_command_t    cmd;
  logic                wdata_valid;
  logic                wdata_accept;
  corebus_write_data_t wdata;
  logic                resp_valid;
  logic                resp_accept;
  corebus_response_t   resp;

  corebus_slicer #(
    .STAGES (STAGES )
  ) u_slicer (
    .i_clk          (i_clk          ),
    .i_rst_n        (i_rst_n        ),
    .i_cmd_valid    (i_cmd_valid    ),
    .o_cmd_accept   (o_cmd_accept   ),
    .i_cmd          (i_cmd          ),
    .i_wdata_valid  (i_wdata_valid  ),
    .o_wdata_accept (o_wdata_accept ),
    .i_wdata        (i_wdata        ),
    .o_resp_valid   (o_resp_valid   ),
    .i_resp_accept  (i_resp_accept  ),
    .o_resp         (o_resp         ),
    .o_cmd_valid    (cmd_valid      ),
    .i_cmd_accept   (cmd_accept     ),
    .o_cmd          (cmd            ),
    .o_wdata_valid  (wdata_valid    ),
    .i_wdata_accept (wdata_accept   ),
    .o_wdata        (wdata          ),
    .i_resp_valid   (resp_valid     ),
    .o_resp_accept  (resp_accept    ),
    .i_resp         (resp           )
  );

  corebus_mem_target u_target (
    .i_clk          (i_clk        ),
    .i_rst_n        (i_rst_n      ),
    .i_cmd_valid    (cmd_valid    ),
    .o_cmd_accept   (cmd_accept   ),
    .i_cmd          (cmd          ),
    .i_wdata_valid  (wdata_valid  ),
    .o_wdata_accept (wdata_accept ),
    .i_wdata        (wdata        ),
    .o_resp_valid   (resp_valid   ),
    .i_resp_accept  (resp_accept  ),
    .o_resp         (resp         )
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
/* testbench clock and reset */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
)(
  output var logic o_clk,
  output var logic o_rst_n
);
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // release just after an edge, like the other inputs.
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_corebus_top.sv
/* corebus slicer and memory target testbench */
`timescale 1ns/10ps
`default_nettype none

module tb_corebus_top;
  import corebus_pkg::*;

  localparam int HANDSHAKE_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT     = 5000;
  localparam int RESET_TIMEOUT     = 20;

  logic                i_clk;
  logic                i_rst_n;
  logic                i_cmd_valid;
  logic                o_cmd_accept;
  corebus_command_t    i_cmd;
  logic                i_wdata_valid;
  logic                o_wdata_accept;
  corebus_write_data_t i_wdata;
  logic                o_resp_valid;
  logic                i_resp_accept;
  corebus_response_t   o_resp;

  corebus_data_t       ref_mem [MEM_WORDS];
  corebus_response_t   exp_q [$];
  logic [31:0]         stim_state;
  logic [31:0]         stall_state;
  logic                stall_enable;
  string               cur_test;
  int                  errors;
  int                  checks;

  tb_clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (3 )
  ) u_clock_gen (
    .o_clk   (i_clk   ),
    .o_rst_n (i_rst_n )
  );

  corebus_top #(
    .STAGES (2)
  ) dut0 (
    .i_clk          (i_clk          ),
    .i_rst_n        (i_rst_n        ),
    .i_cmd_valid    (i_cmd_valid    ),
    .o_cmd_accept   (o_cmd_accept   ),
    .i_cmd          (i_cmd          ),
    .i_wdata_valid  (i_wdata_valid  ),
    .o_wdata_accept (o_wdata_accept ),
    .i_wdata        (i_wdata        ),
    .o_resp_valid   (o_resp_valid   ),
    .i_resp_accept  (i_resp_accept  ),
    .o_resp         (o_resp         )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // depends on every address bit.
  function automatic corebus_data_t fill_word(input corebus_addr_t a);
    return {8'ha5, a, ~a, a ^ 8'h5a};
  endfunction

  // expected responses of one command, in order.
  function automatic void model_memory(input corebus_command_t cmd,
                                       input corebus_data_t beats [4]);
    corebus_response_t rsp;
    logic              err;
    int                i;
    err = (int'(cmd.addr) + int'(cmd.len)) >= MEM_WORDS;
    rsp.id    = cmd.id;
    rsp.error = err;
    if (cmd.opcode == CMD_WRITE) begin
      if (!err) begin
        for (i = 0; i <= int'(cmd.len); i++) begin
          ref_mem[int'(cmd.addr) + i] = beats[i];
        end
      end
      rsp.kind = CMD_WRITE;
      rsp.data = '0;
      rsp.last = 1'b1;
      exp_q.push_back(rsp);
    end else begin
      rsp.kind = CMD_READ;
      for (i = 0; i <= int'(cmd.len); i++) begin
        rsp.data = err ? '0 : ref_mem[int'(cmd.addr) + i];
        rsp.last = (i == int'(cmd.len));
        exp_q.push_back(rsp);
      end
    end
  endfunction

  task automatic next_rand(output logic [31:0] r);
    stim_state = lcg_next(stim_state);
    r = stim_state;
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR %s: %s expected %b actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // called and returns just after a rising edge.
  task automatic send_command(input corebus_command_t cmd);
    int   cycles;
    logic done;
    i_cmd       = cmd;
    i_cmd_valid = 1'b1;
    cycles      = 0;
    done        = 1'b0;
    while (!done) begin
      @(negedge i_clk);
      if (o_cmd_accept) begin
        done = 1'b1;
      end else if (cycles >= HANDSHAKE_TIMEOUT) begin
        abort_run("command was not accepted before the timeout");
      end
      cycles++;
    end
    @(posedge i_clk);
    #1;
    i_cmd_valid = 1'b0;
  endtask

  task automatic send_beat(input corebus_data_t data, input logic last);
    int   cycles;
    logic done;
    i_wdata.data  = data;
    i_wdata.last  = last;
    i_wdata_valid = 1'b1;
    cycles        = 0;
    done          = 1'b0;
    while (!done) begin
      @(negedge i_clk);
      if (o_wdata_accept) begin
        done = 1'b1;
      end else if (cycles >= HANDSHAKE_TIMEOUT) begin
        abort_run("write data beat was not accepted before the timeout");
      end
      cycles++;
    end
    @(posedge i_clk);
    #1;
    i_wdata_valid = 1'b0;
  endtask

  task automatic run_command(input corebus_opcode_e op, input corebus_id_t id,
                             input corebus_addr_t addr, input corebus_len_t len,
                             input corebus_data_t beats [4]);
    corebus_command_t cmd;
    int               i;
    cmd.opcode = op;
    cmd.id     = id;
    cmd.addr   = addr;
    cmd.len    = len;
    model_memory(cmd, beats);
    send_command(cmd);
    if (op == CMD_WRITE) begin
      for (i = 0; i <= int'(len); i++) begin
        send_beat(beats[i], i == int'(len));
      end
    end
  endtask

  task automatic run_random_data(input corebus_opcode_e op, input corebus_id_t id,
                                 input corebus_addr_t addr, input corebus_len_t len);
    corebus_data_t beats [4];
    logic [31:0]   r;
    int            i;
    for (i = 0; i < 4; i++) begin
      next_rand(r);
      beats[i] = r;
    end
    run_command(op, id, addr, len, beats);
  endtask

  task automatic wait_drained;
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run($sformatf("%0d expected responses did not arrive in %s",
                            exp_q.size(), cur_test));
      end
    end
    @(posedge i_clk);
    #1;
  endtask

  // response accept is random while stalling is on.
  initial begin
    i_resp_accept = 1'b1;
    stall_state   = 32'he360;
    forever begin
      @(posedge i_clk);
      #1;
      if (stall_enable) begin
        stall_state   = lcg_next(stall_state);
        i_resp_accept = stall_state[31];
      end else begin
        i_resp_accept = 1'b1;
      end
    end
  end

  // sampled mid-cycle before the edge that transfers.
  initial begin
    corebus_response_t exp;
    corebus_response_t held_resp;
    logic              held_valid;
    held_valid = 1'b0;
    held_resp  = '0;
    forever begin
      @(negedge i_clk);
      if (i_rst_n) begin
        if (held_valid) begin
          checks++;
          assert (o_resp_valid === 1'b1 && o_resp === held_resp) else begin
            $display("ERROR %s: stalled response expected %h actual valid=%b resp=%h",
                     cur_test, held_resp, o_resp_valid, o_resp);
            errors++;
          end
        end
        held_valid = o_resp_valid && !i_resp_accept;
        held_resp  = o_resp;
        if (o_resp_valid && i_resp_accept) begin
          assert (exp_q.size() != 0) else begin
            $display("a response arrived in %s when none was expected", cur_test);
            errors++;
          end
          if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            checks++;
            assert (o_resp === exp) else begin
              $write("ERROR %s: expected kind=%0d id=%h data=%h error=%b last=%b",
                     cur_test, exp.kind, exp.id, exp.data, exp.error, exp.last);
              $display(", actual kind=%0d id=%h data=%h error=%b last=%b",
                       o_resp.kind, o_resp.id, o_resp.data, o_resp.error, o_resp.last);
              errors++;
            end
          end
        end
      end
    end
  end

  initial begin
    corebus_data_t beats [4];
    logic [31:0]   r;
    corebus_len_t  len;
    corebus_addr_t addr;
    int            cycles;
    int            i;
    int            k;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_wdata_valid = 1'b0;
    i_wdata       = '0;
    stall_enable  = 1'b0;
    stim_state    = 32'he360;
    errors        = 0;
    checks        = 0;
    cur_test      = "reset";

    cycles = 0;
    while (i_rst_n !== 1'b1) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        abort_run("reset was never released");
      end
    end

    // slice stages come out of reset empty and accepting.
    @(negedge i_clk);
    check_bit("o_resp_valid", 1'b0, o_resp_valid);
    check_bit("o_cmd_accept", 1'b1, o_cmd_accept);
    check_bit("o_wdata_accept", 1'b1, o_wdata_accept);
    @(posedge i_clk);
    #1;

    cur_test = "fill";
    for (k = 0; k < MEM_WORDS / 4; k++) begin
      for (i = 0; i < 4; i++) begin
        beats[i] = fill_word(corebus_addr_t'(k * 4 + i));
      end
      run_command(CMD_WRITE, corebus_id_t'(k), corebus_addr_t'(k * 4), 2'd3, beats);
    end
    wait_drained();

    cur_test = "single";
    repeat (8) begin
      next_rand(r);
      addr = {2'b00, r[21:16]};
      run_random_data(CMD_WRITE, r[3:0], addr, 2'd0);
      run_random_data(CMD_READ, r[7:4], addr, 2'd0);
    end
    wait_drained();

    cur_test = "burst";
    repeat (12) begin
      next_rand(r);
      len  = corebus_len_t'(1 + r[23:16] % 3);
      addr = corebus_addr_t'(r[15:8] % (MEM_WORDS - len));
      run_random_data(CMD_WRITE, r[3:0], addr, len);
      run_random_data(CMD_READ, r[7:4], addr, len);
    end
    wait_drained();

    cur_test = "error";
    run_random_data(CMD_WRITE, 4'h1, 8'd62, 2'd3);
    run_random_data(CMD_READ, 4'h2, 8'd62, 2'd2);
    run_random_data(CMD_READ, 4'h3, 8'd200, 2'd0);
    run_random_data(CMD_READ, 4'h4, 8'd63, 2'd1);
    run_random_data(CMD_WRITE, 4'h5, 8'd255, 2'd0);
    // this in-range read shows the rejected writes left memory alone.
    run_random_data(CMD_READ, 4'h6, 8'd60, 2'd3);
    wait_drained();

    cur_test     = "random";
    stall_enable = 1'b1;
    repeat (200) begin
      next_rand(r);
      addr = (r[15:13] == 3'd0) ? r[23:16] : {2'b00, r[21:16]};
      run_random_data(r[0] ? CMD_WRITE : CMD_READ, r[7:4], addr, r[9:8]);
    end
    wait_drained();
    stall_enable = 1'b0;

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/corebus_pkg.sv
rtl/corebus_slice_stage.sv
rtl/corebus_slice_chain.sv
rtl/corebus_slicer.sv
rtl/corebus_mem_target.sv
rtl/corebus_top.sv
verif/tb_clock_gen.sv
verif/tb_corebus_top.sv
